// File: include/div_defines.svh
`ifndef DIV_DEFINES_SVH
`define DIV_DEFINES_SVH

// Operand width in bits, 2 or more
`define DIV_WIDTH 8

// Iteration counter must hold the value DIV_WIDTH
`define DIV_CNT_WIDTH ($clog2(`DIV_WIDTH) + 1)

`endif

// File: src/div_pkg.sv
`default_nettype none

`include "div_defines.svh"

package div_pkg;

    typedef enum logic [2:0] {
        IDLE          = 3'b000,
        LOADING       = 3'b001,
        CHECK_DIVISOR = 3'b010,
        DIVIDE        = 3'b011,
        SUB           = 3'b100,
        SHIFT_LEFT    = 3'b101,
        DONE          = 3'b110
    } div_state_e;

    typedef struct packed {
        logic [`DIV_WIDTH-1:0] dividend;
        logic [`DIV_WIDTH-1:0] divisor;
    } div_operands_t;

    typedef struct packed {
        logic load;   // Clear remainder, load dividend, clear counter
        logic shift;  // Shift {remainder, quotient} left by one
        logic sub;    // Subtract divisor, set quotient LSB
        logic finish; // Capture result
    } div_ctrl_t;

    typedef struct packed {
        logic [`DIV_WIDTH-1:0] quotient;
        logic [`DIV_WIDTH-1:0] remainder;
        logic                  div_by_zero;
    } div_result_t;

endpackage

`default_nettype wire

// File: src/div_operand_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_defines.svh"

module div_operand_decode (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  logic                   busy,
    input  div_pkg::div_operands_t operands,
    output div_pkg::div_operands_t operands_q,
    output logic                   dvz
);

    logic accept;

    // Same acceptance rule as the FSM, a start while busy is dropped
    assign accept = start & ~busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operands_q <= '0;
        end else if (accept) begin
            operands_q <= operands;
        end
    end

    // Checked on the held copy, valid from LOADING onward
    assign dvz = (operands_q.divisor == '0);

endmodule

`default_nettype wire

// File: src/div_control.sv
`timescale 1ns/10ps
`default_nettype none

module div_control (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               start,
    input  logic               dvz,
    input  logic               gt,
    input  logic               cnt_done,
    output div_pkg::div_ctrl_t ctrl,
    output logic               busy
);

    import div_pkg::*;

    div_state_e state_q;
    div_state_e state_d;
    logic       fin_q; // High in the cycle that done is high

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
            fin_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            fin_q   <= ctrl.finish;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start && !busy) begin
                    state_d = LOADING;
                end
            end
            LOADING: begin
                state_d = CHECK_DIVISOR;
            end
            CHECK_DIVISOR: begin
                if (dvz) begin
                    state_d = DONE;
                end else begin
                    state_d = SHIFT_LEFT;
                end
            end
            SHIFT_LEFT: begin
                state_d = DIVIDE;
            end
            DIVIDE: begin
                if (gt) begin
                    state_d = SUB;
                end else if (cnt_done) begin
                    state_d = DONE;
                end else begin
                    state_d = SHIFT_LEFT;
                end
            end
            SUB: begin
                if (cnt_done) begin
                    state_d = DONE;
                end else begin
                    state_d = SHIFT_LEFT;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // One strobe per state, decoded from the registered state
    always_comb begin
        ctrl        = '0;
        ctrl.load   = (state_q == LOADING);
        ctrl.shift  = (state_q == SHIFT_LEFT);
        ctrl.sub    = (state_q == SUB);
        ctrl.finish = (state_q == DONE);
    end

    // Stays up through the done cycle
    assign busy = (state_q != IDLE) | fin_q;

endmodule

`default_nettype wire

// File: src/div_shift_sub.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_defines.svh"

module div_shift_sub (
    input  logic                   clk,
    input  logic                   arst_n,
    input  div_pkg::div_ctrl_t     ctrl,
    input  div_pkg::div_operands_t operands_q,
    output logic                   gt,
    output logic                   cnt_done,
    output div_pkg::div_result_t   work
);

    localparam logic [`DIV_CNT_WIDTH-1:0] CNT_LAST = `DIV_WIDTH;

    logic [`DIV_WIDTH:0]       rem_q;   // Extra bit catches the shift carry
    logic [`DIV_WIDTH-1:0]     quo_q;
    logic [`DIV_CNT_WIDTH-1:0] cnt_q;
    logic [`DIV_WIDTH:0]       divisor_ext;
    logic [`DIV_WIDTH:0]       diff;

    assign divisor_ext = {1'b0, operands_q.divisor};
    assign diff        = rem_q - divisor_ext;
    assign gt          = (rem_q >= divisor_ext);
    assign cnt_done    = (cnt_q == CNT_LAST);

    always_ff @(posedge clk) begin
        if (ctrl.load) begin
            rem_q <= '0;
            quo_q <= operands_q.dividend;
        end else if (ctrl.shift) begin
            rem_q <= {rem_q[`DIV_WIDTH-1:0], quo_q[`DIV_WIDTH-1]};
            quo_q <= {quo_q[`DIV_WIDTH-2:0], 1'b0};
        end else if (ctrl.sub) begin
            rem_q    <= diff;
            quo_q[0] <= 1'b1;
        end
    end

    // One count per shift
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (ctrl.load) begin
            cnt_q <= '0;
        end else if (ctrl.shift) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Final remainder is below the divisor, top bit is zero by then
    assign work.quotient    = quo_q;
    assign work.remainder   = rem_q[`DIV_WIDTH-1:0];
    assign work.div_by_zero = 1'b0;

endmodule

`default_nettype wire

// File: src/div_result.sv
`timescale 1ns/10ps
`default_nettype none

module div_result (
    input  logic                 clk,
    input  logic                 arst_n,
    input  div_pkg::div_ctrl_t   ctrl,
    input  logic                 dvz,
    input  div_pkg::div_result_t work,
    output div_pkg::div_result_t result,
    output logic                 done
);

    import div_pkg::*;

    div_result_t res_d;

    always_comb begin
        res_d = work;
        if (dvz) begin
            res_d.quotient    = '1;
            res_d.remainder   = work.quotient; // No shifts ran, still the dividend
            res_d.div_by_zero = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= ctrl.finish;
            if (ctrl.finish) begin
                result <= res_d; // Held until the next finish
            end
        end
    end

endmodule

`default_nettype wire

// File: src/div_top.sv
`timescale 1ns/10ps
`default_nettype none

module div_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   start,
    input  div_pkg::div_operands_t operands,
    output logic                   busy,
    output logic                   done,
    output div_pkg::div_result_t   result
);

    import div_pkg::*;

    div_operands_t operands_q;
    div_ctrl_t     ctrl;
    div_result_t   work;
    logic          dvz;
    logic          gt;
    logic          cnt_done;

    div_operand_decode u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .busy       (busy),
        .operands   (operands),
        .operands_q (operands_q),
        .dvz        (dvz)
    );

    div_control u_control (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .dvz      (dvz),
        .gt       (gt),
        .cnt_done (cnt_done),
        .ctrl     (ctrl),
        .busy     (busy)
    );

    div_shift_sub u_shift_sub (
        .clk        (clk),
        .arst_n     (arst_n),
        .ctrl       (ctrl),
        .operands_q (operands_q),
        .gt         (gt),
        .cnt_done   (cnt_done),
        .work       (work)
    );

    div_result u_result (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl),
        .dvz    (dvz),
        .work   (work),
        .result (result),
        .done   (done)
    );

endmodule

`default_nettype wire

// File: sim/div_assert.sv
`timescale 1ns/10ps
`default_nettype none

module div_assert (
    input logic                   clk,
    input logic                   arst_n,
    input logic                   start,
    input logic                   busy,
    input logic                   done,
    input div_pkg::div_ctrl_t     ctrl,
    input div_pkg::div_operands_t operands_q
);

    a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        done |=> !done)
        else $error("done stayed high for more than one cycle");

    // Busy drops in the cycle right after done
    a_busy_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(busy) |-> $past(done))
        else $error("busy fell without a done pulse");

    a_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (start && busy) |=> (!ctrl.load && $stable(operands_q)))
        else $error("start while busy restarted the divider");

endmodule

bind div_top div_assert u_div_assert (
    .clk        (clk),
    .arst_n     (arst_n),
    .start      (start),
    .busy       (busy),
    .done       (done),
    .ctrl       (ctrl),
    .operands_q (operands_q)
);

`default_nettype wire

// File: sim/tb_div_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "div_defines.svh"

module tb_div_top;

    import div_pkg::*;

    localparam int W            = `DIV_WIDTH;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_TESTS    = NUM_RANDOM + 16;
    localparam int LAT_MIN      = 2 * W + 4;
    localparam int LAT_MAX      = 3 * W + 4;
    localparam int LAT_DVZ      = 4;

    logic          clk;
    logic          arst_n;
    logic          start;
    div_operands_t operands;
    logic          busy;
    logic          done;
    div_result_t   result;

    logic [15:0]   lfsr_state  = 16'd33181;
    int            cycle_cnt   = 0;
    int            started_cnt = 0;
    int            done_cnt    = 0;
    div_result_t   exp_q[$];     // Expected results in start order
    int            start_cyc_q[$];

    div_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .operands (operands),
        .busy     (busy),
        .done     (done),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Taps for x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_word(output logic [W-1:0] v);
        v = '0;
        for (int i = 0; i < W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v          = {v[W-2:0], lfsr_state[0]};
        end
    endtask

    function automatic div_operands_t make_ops(input logic [W-1:0] dividend,
                                               input logic [W-1:0] divisor);
        div_operands_t ops;
        ops.dividend = dividend;
        ops.divisor  = divisor;
        return ops;
    endfunction

    function automatic div_result_t ref_divide(input div_operands_t ops);
        div_result_t r;
        if (ops.divisor == '0) begin
            r.quotient    = '1;
            r.remainder   = ops.dividend;
            r.div_by_zero = 1'b1;
        end else begin
            r.quotient    = ops.dividend / ops.divisor;
            r.remainder   = ops.dividend % ops.divisor;
            r.div_by_zero = 1'b0;
        end
        return r;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(input div_result_t got, input div_result_t exp);
        if (got.quotient !== exp.quotient) begin
            fail_run($sformatf("MISMATCH at %0t: quotient got %h expected %h",
                               $time, got.quotient, exp.quotient));
        end
        if (got.remainder !== exp.remainder) begin
            fail_run($sformatf("MISMATCH at %0t: remainder got %h expected %h",
                               $time, got.remainder, exp.remainder));
        end
        if (got.div_by_zero !== exp.div_by_zero) begin
            fail_run($sformatf("MISMATCH at %0t: div_by_zero got %b expected %b",
                               $time, got.div_by_zero, exp.div_by_zero));
        end
    endtask

    task automatic check_idle(input logic busy_v, input logic done_v);
        if (busy_v !== 1'b0 || done_v !== 1'b0) begin
            fail_run($sformatf("MISMATCH at %0t: busy/done got %b/%b expected 0/0",
                               $time, busy_v, done_v));
        end
    endtask

    task automatic check_latency(input int got, input int lo, input int hi);
        if (got < lo || got > hi) begin
            fail_run($sformatf("MISMATCH at %0t: latency got %0d expected %0d..%0d",
                               $time, got, lo, hi));
        end
    endtask

    task automatic start_division(input div_operands_t ops);
        @(posedge clk);
        #5;
        start    = 1'b1;
        operands = ops;
        exp_q.push_back(ref_divide(ops));
        start_cyc_q.push_back(cycle_cnt);
        started_cnt++;
        @(posedge clk);
        #5;
        start = 1'b0;
    endtask

    task automatic run_division(input div_operands_t ops);
        start_division(ops);
        wait (done_cnt == started_cnt);
    endtask

    initial begin : compare
        div_result_t exp;
        int          start_cyc;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (done === 1'b1) begin
                if (exp_q.size() == 0) begin
                    fail_run("done pulse seen with no division in progress");
                end
                exp       = exp_q.pop_front();
                start_cyc = start_cyc_q.pop_front();
                check_result(result, exp);
                if (exp.div_by_zero) begin
                    check_latency(cycle_cnt - start_cyc, LAT_DVZ, LAT_DVZ);
                end else begin
                    check_latency(cycle_cnt - start_cyc, LAT_MIN, LAT_MAX);
                end
                done_cnt++;
                @(negedge clk);
                check_idle(busy, done);
            end
        end
    end

    initial begin : watchdog
        #((NUM_TESTS * 40 + RESET_CYCLES) * CLK_PERIOD);
        fail_run("Timeout: the divider did not finish all tests in time");
    end

    initial begin : stimulus
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] all_ones;
        arst_n   = 1'b0;
        start    = 1'b0;
        operands = '0;
        all_ones = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        arst_n = 1'b1;
        @(negedge clk);
        check_idle(busy, done);
        check_result(result, '0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_word(a);
            do begin
                draw_word(b);
            end while (b == '0);
            run_division(make_ops(a, b));
        end

        draw_word(a);
        run_division(make_ops(a, '0));
        run_division(make_ops('0, '0));
        run_division(make_ops(all_ones, '0));

        // Edge operands
        do begin
            draw_word(a);
        end while (a == '0);
        run_division(make_ops('0, a));
        run_division(make_ops(a, 1));
        run_division(make_ops(a, a));
        run_division(make_ops(all_ones, all_ones));
        run_division(make_ops(all_ones, 1));
        run_division(make_ops(1, all_ones));
        run_division(make_ops(all_ones >> 1, all_ones));

        // Second start lands in DIVIDE and must be dropped
        start_division(make_ops(all_ones, a));
        repeat (3) @(posedge clk);
        #5;
        start    = 1'b1;
        operands = make_ops(a, 1);
        @(posedge clk);
        #5;
        start = 1'b0;
        wait (done_cnt == started_cnt);
        repeat (LAT_MAX + 4) @(posedge clk);

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: seq_divider.f
+incdir+include
src/div_pkg.sv
src/div_operand_decode.sv
src/div_control.sv
src/div_shift_sub.sv
src/div_result.sv
src/div_top.sv
sim/div_assert.sv
sim/tb_div_top.sv

// File: Bender.yml
package:
  name: seq_divider

sources:
  - include_dirs:
      - include
    files:
      - src/div_pkg.sv
      - src/div_operand_decode.sv
      - src/div_control.sv
      - src/div_shift_sub.sv
      - src/div_result.sv
      - src/div_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/div_assert.sv
      - sim/tb_div_top.sv
